//--- verilog/cc_settings.svh
// widths, buffer depth and element size shared by the
// connected-components edge stage, its package and its testbench

`ifndef CC_SETTINGS_SVH
`define CC_SETTINGS_SVH

// vertex / component index width
`define CC_INDEX_W 32

// byte address width of the component array
`define CC_ADDR_W 64

// bytes per component element
`define CC_DATA_BYTES 4

// entries in the job and update buffers
`define CC_FIFO_DEPTH 16

// free entries left when almost-full is raised
`define CC_ALFULL_MARGIN 2

`define CC_SKIP_W 32

`endif

//--- verilog/cc_pkg.sv
// types for the connected-components edge stage
//   cc_read_kind_t   tag on read commands and responses
//   cc_edge_job_t    one edge from the job stream
//   cc_comp_update_t update record handed to the consumer

`include "cc_settings.svh"

package cc_pkg;

	// which component a read fetches
	typedef enum logic [1:0] {
		CC_READ_SRC  = 2'd0,
		CC_READ_DEST = 2'd1,
		CC_READ_HIGH = 2'd2
	} cc_read_kind_t;

	typedef struct packed {
		logic [`CC_INDEX_W-1:0] src;
		logic [`CC_INDEX_W-1:0] dest;
	} cc_edge_job_t;

	// comp_comp_high is the component stored at index comp_high
	typedef struct packed {
		logic [`CC_INDEX_W-1:0] comp_high;
		logic [`CC_INDEX_W-1:0] comp_low;
		logic [`CC_INDEX_W-1:0] comp_comp_high;
	} cc_comp_update_t;

endpackage

//--- verilog/cc_edge_if.sv
// decision and completion signals between the issue, compare
// and result stages of the edge pipeline

`include "cc_settings.svh"

interface cc_edge_if;

	// one pulse per job from the compare stage
	logic                   decision_valid;
	logic                   skip;
	logic [`CC_INDEX_W-1:0] comp_high;
	logic [`CC_INDEX_W-1:0] comp_low;

	// result stage status
	logic                   job_done;
	logic                   upd_alfull;

	modport compare_side (output decision_valid, skip, comp_high, comp_low);
	modport issue_side (input decision_valid, skip, comp_high, comp_low, job_done, upd_alfull);
	modport result_side (input decision_valid, skip, comp_high, comp_low,
		output job_done, upd_alfull);

endinterface

//--- verilog/cc_fifo.sv
// show-ahead circular buffer with a payload type parameter
// head entry is on data_out while empty is low

`include "cc_settings.svh"

module cc_fifo #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     push,
	input  payload_t data_in,
	input  logic     pop,
	output payload_t data_out,
	output logic     empty,
	output logic     alfull
);

	localparam int DEPTH  = `CC_FIFO_DEPTH;
	localparam int MARGIN = `CC_ALFULL_MARGIN;
	localparam int PTR_W  = $clog2(DEPTH);
	localparam int CNT_W  = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	logic do_push;
	logic do_pop;

	assign full    = (count == CNT_W'(DEPTH));
	assign empty   = (count == '0);
	assign alfull  = (count >= CNT_W'(DEPTH - MARGIN));
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- verilog/cc_read_issue.sv
// decode stage
//   edge job buffer
//   FSM that pops one job at a time and issues the SRC, DEST
//   and HIGH component reads as registered command pulses

`include "cc_settings.svh"

module cc_read_issue (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    edge_valid,
	input  cc_pkg::cc_edge_job_t    edge_job,
	input  logic [`CC_ADDR_W-1:0]   base_address,
	input  logic                    cmd_stall,
	output logic                    cmd_valid,
	output cc_pkg::cc_read_kind_t   cmd_kind,
	output logic [`CC_INDEX_W-1:0]  cmd_index,
	output logic [`CC_ADDR_W-1:0]   cmd_address,
	output logic                    edge_request,
	cc_edge_if.issue_side           bus
);

	localparam int ADDR_SHIFT = $clog2(`CC_DATA_BYTES);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SRC,
		ST_DEST,
		ST_WAIT_DEC,
		ST_HIGH,
		ST_WAIT_DONE
	} state_t;

	state_t state;
	cc_pkg::cc_edge_job_t job_head;
	cc_pkg::cc_edge_job_t job_q;
	logic [`CC_INDEX_W-1:0] high_q;
	logic job_empty;
	logic job_alfull;
	logic job_pop;
	logic issue;
	cc_pkg::cc_read_kind_t issue_kind;
	logic [`CC_INDEX_W-1:0] issue_index;

	cc_fifo #(.payload_t(cc_pkg::cc_edge_job_t)) job_fifo_i (
		.clock    (clock),
		.rstn     (rstn),
		.push     (edge_valid),
		.data_in  (edge_job),
		.pop      (job_pop),
		.data_out (job_head),
		.empty    (job_empty),
		.alfull   (job_alfull)
	);

	assign edge_request = !job_alfull;
	assign job_pop = (state == ST_IDLE) && !job_empty && !bus.upd_alfull && !cmd_stall;

	// pick the command for this cycle
	always_comb begin
		issue       = 1'b0;
		issue_kind  = cc_pkg::CC_READ_SRC;
		issue_index = job_head.src;
		case (state)
			ST_IDLE: issue = job_pop;
			ST_DEST: begin
				issue       = !cmd_stall;
				issue_kind  = cc_pkg::CC_READ_DEST;
				issue_index = job_q.dest;
			end
			ST_HIGH: begin
				issue       = !cmd_stall;
				issue_kind  = cc_pkg::CC_READ_HIGH;
				issue_index = high_q;
			end
			default: issue = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// job sequencing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= ST_IDLE;
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= issue;
			case (state)
				ST_IDLE:      if (job_pop) state <= ST_SRC;
				// gap cycle after the SRC pulse
				ST_SRC:       state <= ST_DEST;
				ST_DEST:      if (issue) state <= ST_WAIT_DEC;
				ST_WAIT_DEC: begin
					if (bus.decision_valid) begin
						state <= bus.skip ? ST_IDLE : ST_HIGH;
					end
				end
				ST_HIGH:      if (issue) state <= ST_WAIT_DONE;
				ST_WAIT_DONE: if (bus.job_done) state <= ST_IDLE;
				default:      state <= ST_IDLE;
			endcase
		end
	end

	// job and command payload
	always_ff @(posedge clock) begin
		if (job_pop) begin
			job_q <= job_head;
		end
		if (state == ST_WAIT_DEC && bus.decision_valid) begin
			high_q <= bus.comp_high;
		end
		if (issue) begin
			cmd_kind    <= issue_kind;
			cmd_index   <= issue_index;
			cmd_address <= base_address + (`CC_ADDR_W'(issue_index) << ADDR_SHIFT);
		end
	end

endmodule

//--- verilog/cc_component_compare.sv
// execute stage
//   captures the SRC and DEST components in either order
//   decides skip, orders the pair into high/low
//   counts equal pairs

`include "cc_settings.svh"

module cc_component_compare (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    resp_valid,
	input  cc_pkg::cc_read_kind_t   resp_kind,
	input  logic [`CC_INDEX_W-1:0]  resp_data,
	output logic [`CC_SKIP_W-1:0]   skip_count,
	cc_edge_if.compare_side         bus
);

	logic [`CC_INDEX_W-1:0] comp_src;
	logic [`CC_INDEX_W-1:0] comp_dest;
	logic src_ready;
	logic dest_ready;
	logic pair_ready;
	logic pair_equal;
	logic src_is_high;

	assign pair_ready  = src_ready && dest_ready;
	assign pair_equal  = (comp_src == comp_dest);
	assign src_is_high = (comp_src > comp_dest);

	//////////////////////////////////////////////////////////////////////
	// response capture
	//////////////////////////////////////////////////////////////////////

	// HIGH responses belong to the result stage
	always_ff @(posedge clock) begin
		if (resp_valid && resp_kind == cc_pkg::CC_READ_SRC) begin
			comp_src <= resp_data;
		end
		if (resp_valid && resp_kind == cc_pkg::CC_READ_DEST) begin
			comp_dest <= resp_data;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			src_ready  <= 1'b0;
			dest_ready <= 1'b0;
		end else if (pair_ready) begin
			src_ready  <= 1'b0;
			dest_ready <= 1'b0;
		end else if (resp_valid) begin
			if (resp_kind == cc_pkg::CC_READ_SRC) src_ready <= 1'b1;
			if (resp_kind == cc_pkg::CC_READ_DEST) dest_ready <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// decision
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			bus.decision_valid <= 1'b0;
			skip_count         <= '0;
		end else begin
			bus.decision_valid <= pair_ready;
			if (pair_ready && pair_equal) begin
				skip_count <= skip_count + 1'b1;
			end
		end
	end

	// held until the next pair
	always_ff @(posedge clock) begin
		if (pair_ready) begin
			bus.skip      <= pair_equal;
			bus.comp_high <= src_is_high ? comp_src : comp_dest;
			bus.comp_low  <= src_is_high ? comp_dest : comp_src;
		end
	end

endmodule

//--- verilog/cc_update_result.sv
// result stage
//   keeps high/low from the decision, waits for the HIGH read
//   and pushes the update record into the output buffer

`include "cc_settings.svh"

module cc_update_result (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    resp_valid,
	input  cc_pkg::cc_read_kind_t   resp_kind,
	input  logic [`CC_INDEX_W-1:0]  resp_data,
	input  logic                    upd_pop,
	output logic                    upd_empty,
	output cc_pkg::cc_comp_update_t upd_data,
	cc_edge_if.result_side          bus
);

	cc_pkg::cc_comp_update_t record;
	logic push_q;

	// record fields
	always_ff @(posedge clock) begin
		if (bus.decision_valid && !bus.skip) begin
			record.comp_high <= bus.comp_high;
			record.comp_low  <= bus.comp_low;
		end
		if (resp_valid && resp_kind == cc_pkg::CC_READ_HIGH) begin
			record.comp_comp_high <= resp_data;
		end
	end

	// push one cycle after the HIGH response
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			push_q <= 1'b0;
		end else begin
			push_q <= resp_valid && (resp_kind == cc_pkg::CC_READ_HIGH);
		end
	end

	assign bus.job_done = push_q;

	cc_fifo #(.payload_t(cc_pkg::cc_comp_update_t)) update_fifo_i (
		.clock    (clock),
		.rstn     (rstn),
		.push     (push_q),
		.data_in  (record),
		.pop      (upd_pop),
		.data_out (upd_data),
		.empty    (upd_empty),
		.alfull   (bus.upd_alfull)
	);

endmodule

//--- verilog/cc_edge_data_read.sv
// top level of the connected-components edge stage
//   job intake and read issue, component compare,
//   update record buffer, all on plain ports

`include "cc_settings.svh"

module cc_edge_data_read (
	input  logic                    clock,
	input  logic                    rstn,

	// edge jobs
	input  logic                    edge_valid,
	input  logic [`CC_INDEX_W-1:0]  edge_src,
	input  logic [`CC_INDEX_W-1:0]  edge_dest,
	output logic                    edge_request,

	// read commands
	input  logic [`CC_ADDR_W-1:0]   base_address,
	input  logic                    cmd_stall,
	output logic                    cmd_valid,
	output logic [`CC_ADDR_W-1:0]   cmd_address,
	output cc_pkg::cc_read_kind_t   cmd_kind,
	output logic [`CC_INDEX_W-1:0]  cmd_index,

	// read responses
	input  logic                    resp_valid,
	input  cc_pkg::cc_read_kind_t   resp_kind,
	input  logic [`CC_INDEX_W-1:0]  resp_data,

	// update records
	input  logic                    upd_pop,
	output logic                    upd_empty,
	output logic [`CC_INDEX_W-1:0]  upd_high,
	output logic [`CC_INDEX_W-1:0]  upd_low,
	output logic [`CC_INDEX_W-1:0]  upd_comp,

	output logic [`CC_SKIP_W-1:0]   skip_count
);

	cc_pkg::cc_edge_job_t edge_job;
	cc_pkg::cc_comp_update_t upd_data;

	cc_edge_if edge_bus ();

	assign edge_job.src  = edge_src;
	assign edge_job.dest = edge_dest;

	cc_read_issue read_issue_i (
		.clock        (clock),
		.rstn         (rstn),
		.edge_valid   (edge_valid),
		.edge_job     (edge_job),
		.base_address (base_address),
		.cmd_stall    (cmd_stall),
		.cmd_valid    (cmd_valid),
		.cmd_kind     (cmd_kind),
		.cmd_index    (cmd_index),
		.cmd_address  (cmd_address),
		.edge_request (edge_request),
		.bus          (edge_bus.issue_side)
	);

	cc_component_compare component_compare_i (
		.clock      (clock),
		.rstn       (rstn),
		.resp_valid (resp_valid),
		.resp_kind  (resp_kind),
		.resp_data  (resp_data),
		.skip_count (skip_count),
		.bus        (edge_bus.compare_side)
	);

	cc_update_result update_result_i (
		.clock      (clock),
		.rstn       (rstn),
		.resp_valid (resp_valid),
		.resp_kind  (resp_kind),
		.resp_data  (resp_data),
		.upd_pop    (upd_pop),
		.upd_empty  (upd_empty),
		.upd_data   (upd_data),
		.bus        (edge_bus.result_side)
	);

	// head record onto the output ports
	assign upd_high = upd_data.comp_high;
	assign upd_low  = upd_data.comp_low;
	assign upd_comp = upd_data.comp_comp_high;

endmodule

//--- tests/cc_edge_data_read_assert.sv
// concurrent checks on the edge stage top level
//   command pulses are single cycle
//   no pop from an empty update buffer
//   no command right after a stalled edge

module cc_edge_data_read_assert (
	input logic clock,
	input logic rstn,
	input logic cmd_valid,
	input logic cmd_stall,
	input logic upd_pop,
	input logic upd_empty
);

	cmd_single_cycle: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |=> !cmd_valid)
		else $error("cmd_valid high on two consecutive cycles");

	pop_not_empty: assert property (@(posedge clock) disable iff (!rstn)
		upd_pop |-> !upd_empty)
		else $error("upd_pop while the update buffer is empty");

	// command is registered, so it follows the stall sample by one edge
	no_cmd_after_stall: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> !$past(cmd_stall))
		else $error("cmd_valid after a stalled edge");

endmodule

bind cc_edge_data_read cc_edge_data_read_assert assert_i (
	.clock     (clock),
	.rstn      (rstn),
	.cmd_valid (cmd_valid),
	.cmd_stall (cmd_stall),
	.upd_pop   (upd_pop),
	.upd_empty (upd_empty)
);

//--- tests/cc_edge_data_read_tb.sv
// testbench for the connected-components edge stage
//   clock and reset, trace reader, edge driver,
//   read memory model with random delays, command and record checks

`include "cc_settings.svh"

module cc_edge_data_read_tb;

	localparam int TIMEOUT = 4000;
	localparam string TRACE_PATH = "tests/cc_trace.txt";
	localparam logic [`CC_ADDR_W-1:0] BASE = 64'h0000_0100_0000_2000;
	localparam int POP_START = `CC_FIFO_DEPTH - `CC_ALFULL_MARGIN;

	logic clock;
	logic rstn;
	logic edge_valid;
	logic [`CC_INDEX_W-1:0] edge_src;
	logic [`CC_INDEX_W-1:0] edge_dest;
	logic edge_request;
	logic [`CC_ADDR_W-1:0] base_address;
	logic cmd_stall;
	logic cmd_valid;
	logic [`CC_ADDR_W-1:0] cmd_address;
	cc_pkg::cc_read_kind_t cmd_kind;
	logic [`CC_INDEX_W-1:0] cmd_index;
	logic resp_valid;
	cc_pkg::cc_read_kind_t resp_kind;
	logic [`CC_INDEX_W-1:0] resp_data;
	logic upd_pop;
	logic upd_empty;
	logic [`CC_INDEX_W-1:0] upd_high;
	logic [`CC_INDEX_W-1:0] upd_low;
	logic [`CC_INDEX_W-1:0] upd_comp;
	logic [`CC_SKIP_W-1:0] skip_count;

	// component table and expectations from the trace
	logic [31:0] table_comp [256];
	logic [31:0] src_q [$];
	logic [31:0] dest_q [$];
	int exp_kind_q [$];
	logic [31:0] exp_index_q [$];
	logic [31:0] rec_high_q [$];
	logic [31:0] rec_low_q [$];
	logic [31:0] rec_comp_q [$];
	int expected_skips;
	int sent;
	bit stall_enable;
	logic [31:0] rng_state;
	int unsigned cycle;
	int stretch;

	// pending replies of the memory model
	bit pend_used [3];
	int unsigned pend_due [3];
	cc_pkg::cc_read_kind_t pend_kind [3];
	logic [31:0] pend_data [3];

	cc_edge_data_read dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task fail_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	task check_value(input string name, input logic [63:0] expected, input logic [63:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s expected %0h actual %0h", name, expected, actual);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	task load_trace();
		int fd;
		int n;
		string line;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] k;
		logic [31:0] h;
		logic [31:0] l;
		logic [31:0] c;
		fd = $fopen(TRACE_PATH, "r");
		if (fd == 0) begin
			fail_run("could not open the trace file");
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() > 0 && line.getc(0) == "T") begin
				n = $sscanf(line, "T %d %d", a, b);
				table_comp[a[7:0]] = b;
			end else if (line.len() > 0 && line.getc(0) == "E") begin
				n = $sscanf(line, "E %d %d %d %d %d %d", a, b, k, h, l, c);
				if (n != 6) begin
					fail_run("malformed edge line in the trace file");
				end
				src_q.push_back(a);
				dest_q.push_back(b);
				exp_kind_q.push_back(int'(cc_pkg::CC_READ_SRC));
				exp_index_q.push_back(a);
				exp_kind_q.push_back(int'(cc_pkg::CC_READ_DEST));
				exp_index_q.push_back(b);
				if (k != 0) begin
					expected_skips++;
				end else begin
					exp_kind_q.push_back(int'(cc_pkg::CC_READ_HIGH));
					exp_index_q.push_back(h);
					rec_high_q.push_back(h);
					rec_low_q.push_back(l);
					rec_comp_q.push_back(c);
				end
			end
		end
		$fclose(fd);
	endtask

	//////////////////////////////////////////////////////////////////////
	// edge driver and record consumer
	//////////////////////////////////////////////////////////////////////

	task send_edges();
		int waited;
		for (int i = 0; i < src_q.size(); i++) begin
			waited = 0;
			@(negedge clock);
			while (!edge_request) begin
				@(negedge clock);
				waited++;
				if (waited > TIMEOUT) begin
					fail_run("edge_request stayed low too long");
				end
			end
			@(posedge clock);
			edge_valid <= 1'b1;
			edge_src   <= src_q[i];
			edge_dest  <= dest_q[i];
			@(posedge clock);
			edge_valid <= 1'b0;
			sent++;
		end
	endtask

	task receive_records();
		int waited;
		int total;
		total = rec_high_q.size();
		for (int i = 0; i < total; i++) begin
			waited = 0;
			@(negedge clock);
			// hold pops back so the update buffer fills
			while (upd_empty || sent <= POP_START) begin
				@(negedge clock);
				waited++;
				if (waited > TIMEOUT) begin
					fail_run("no update record arrived in time");
				end
			end
			check_value("update high", rec_high_q[i], upd_high);
			check_value("update low", rec_low_q[i], upd_low);
			check_value("update comp", rec_comp_q[i], upd_comp);
			@(posedge clock);
			upd_pop <= 1'b1;
			@(posedge clock);
			upd_pop <= 1'b0;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// memory model and command monitor
	//////////////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		int slot;
		logic [63:0] exp_addr;
		if (rstn && cmd_valid) begin
			if (exp_kind_q.size() == 0) begin
				fail_run("a read command appeared with no edge left to serve");
			end
			exp_addr = BASE + 64'(exp_index_q[0]) * `CC_DATA_BYTES;
			check_value("command kind", 64'(exp_kind_q[0]), 64'(cmd_kind));
			check_value("command index", 64'(exp_index_q[0]), 64'(cmd_index));
			check_value("command address", exp_addr, cmd_address);
			void'(exp_kind_q.pop_front());
			void'(exp_index_q.pop_front());
			if (cmd_index > 255) begin
				fail_run("command index is outside the component table");
			end
			slot = -1;
			for (int s = 0; s < 3; s++) begin
				if (!pend_used[s] && slot < 0) slot = s;
			end
			if (slot < 0) begin
				fail_run("more than three reads were outstanding");
			end
			pend_used[slot] = 1'b1;
			pend_due[slot]  = cycle + 1 + (next_random() % 6);
			pend_kind[slot] = cmd_kind;
			pend_data[slot] = table_comp[cmd_index[7:0]];
		end
	end

	// one reply per cycle, earliest due first
	always @(posedge clock) begin
		int best;
		cycle++;
		best = -1;
		for (int s = 0; s < 3; s++) begin
			if (pend_used[s] && pend_due[s] <= cycle) begin
				if (best < 0 || pend_due[s] < pend_due[best]) best = s;
			end
		end
		if (best >= 0) begin
			resp_valid <= 1'b1;
			resp_kind  <= pend_kind[best];
			resp_data  <= pend_data[best];
			pend_used[best] = 1'b0;
		end else begin
			resp_valid <= 1'b0;
		end
	end

	// random stall stretches on the command side
	always @(posedge clock) begin
		logic [31:0] r;
		if (!stall_enable) begin
			cmd_stall <= 1'b0;
		end else if (stretch == 0) begin
			r = next_random();
			cmd_stall <= (r[1:0] == 2'd0);
			stretch = 1 + int'(r[5:3]);
		end else begin
			stretch--;
		end
	end

	initial begin
		rstn = 1'b0;
		edge_valid = 1'b0;
		edge_src = '0;
		edge_dest = '0;
		base_address = BASE;
		cmd_stall = 1'b0;
		resp_valid = 1'b0;
		resp_kind = cc_pkg::CC_READ_SRC;
		resp_data = '0;
		upd_pop = 1'b0;
		rng_state = 32'd17;
		stall_enable = 1'b0;
		load_trace();
		repeat (10) @(posedge clock);
		rstn <= 1'b1;
		@(negedge clock);
		check_value("reset upd_empty", 64'd1, 64'(upd_empty));
		check_value("reset edge_request", 64'd1, 64'(edge_request));
		check_value("reset cmd_valid", 64'd0, 64'(cmd_valid));
		check_value("reset skip_count", 64'd0, 64'(skip_count));
		stall_enable = 1'b1;
		fork
			send_edges();
			receive_records();
		join
		stall_enable = 1'b0;
		@(negedge clock);
		check_value("skip count", 64'(expected_skips), 64'(skip_count));
		check_value("commands left over", 64'd0, 64'(exp_kind_q.size()));
		check_value("records left over", 64'd1, 64'(upd_empty));
		$display("All tests passed!");
		$finish;
	end

endmodule

//--- tests/cc_trace.txt
# T index component
# E src dest skip high low comp_at_high
T 0 0
T 1 0
T 2 2
T 3 2
T 4 4
T 5 1
T 6 6
T 7 3
T 8 8
T 9 8
T 10 5
T 11 11
T 12 7
T 13 13
T 14 9
T 15 15
E 0 1 1 0 0 0
E 2 4 0 4 2 4
E 5 6 0 6 1 6
E 7 12 0 7 3 3
E 8 9 1 0 0 0
E 10 11 0 11 5 11
E 14 13 0 13 9 13
E 15 0 0 15 0 15
E 3 2 1 0 0 0
E 12 10 0 7 5 3
E 9 5 0 8 1 8
E 6 14 0 9 6 8
E 4 7 0 4 3 4
E 11 15 0 15 11 15
E 13 1 0 13 0 13
E 10 12 0 7 5 3
E 2 3 1 0 0 0
E 14 8 0 9 8 8
E 5 10 0 5 1 1
E 0 13 0 13 0 13

//--- cc_edge_data_read.f
+incdir+verilog
verilog/cc_pkg.sv
verilog/cc_edge_if.sv
verilog/cc_fifo.sv
verilog/cc_read_issue.sv
verilog/cc_component_compare.sv
verilog/cc_update_result.sv
verilog/cc_edge_data_read.sv
tests/cc_edge_data_read_assert.sv
tests/cc_edge_data_read_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the edge stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f cc_edge_data_read.f \
	--top-module cc_edge_data_read_tb \
	-Mdir obj_dir

./obj_dir/Vcc_edge_data_read_tb > sim.log 2>&1
cat sim.log

if grep -q "All tests passed!" sim.log; then
	exit 0
else
	exit 1
fi
